//--- core_uarch_pkg.sv
////////////////////////////////////////////////////////////////////////////
// Core micro-architecture types: ROB sizing, operation codes, micro-op,
// execute request and result, and the commit record
////////////////////////////////////////////////////////////////////////////
package core_uarch_pkg;

  import riscv_isa_pkg::*;

  localparam int ROB_DEPTH = 8;

  typedef logic [$clog2(ROB_DEPTH)-1:0] rob_tag_t;

  typedef enum logic [3:0] {
    OP_ADD,
    OP_SUB,
    OP_AND,
    OP_OR,
    OP_XOR,
    OP_SLT,
    OP_MUL
  } alu_op_t;

  typedef struct packed {
    logic     valid;
    alu_op_t  op;
    reg_idx_t rd;
    reg_idx_t rs1;
    reg_idx_t rs2;
    logic     uses_rs2;
    logic     writes_rd;
    xlen_t    imm;
    logic     is_mul;
    logic     illegal;
  } micro_op_t;

  typedef struct packed {
    logic     valid;
    alu_op_t  op;
    rob_tag_t tag;
    reg_idx_t rd;
    logic     writes_rd;
    xlen_t    operand_a;
    xlen_t    operand_b;
  } exec_req_t;

  typedef struct packed {
    logic     valid;
    rob_tag_t tag;
    reg_idx_t rd;
    logic     writes_rd;
    xlen_t    data;
  } exec_result_t;

  typedef struct packed {
    reg_idx_t rd;
    logic     writes_rd;
    logic     illegal;
    xlen_t    data;
  } commit_t;

endpackage

//--- exec_alu.sv
////////////////////////////////////////////////////////////////////////////
// Single-cycle ALU pipe
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module exec_alu
  import riscv_isa_pkg::*;
  import core_uarch_pkg::*;
(
  input  logic         clock,
  input  logic         reset,
  input  exec_req_t    req,
  output exec_result_t result
);

  xlen_t alu_out;

  always_comb begin
    case (req.op)
      OP_SUB:  alu_out = req.operand_a - req.operand_b;
      OP_AND:  alu_out = req.operand_a & req.operand_b;
      OP_OR:   alu_out = req.operand_a | req.operand_b;
      OP_XOR:  alu_out = req.operand_a ^ req.operand_b;
      OP_SLT:  alu_out = {31'd0, $signed(req.operand_a) < $signed(req.operand_b)};
      default: alu_out = req.operand_a + req.operand_b;
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      result.valid <= 1'b0;
    end else begin
      result.valid     <= req.valid;
      result.tag       <= req.tag;
      result.rd        <= req.rd;
      result.writes_rd <= req.writes_rd;
      result.data      <= alu_out;
    end
  end

endmodule

//--- exec_mul.sv
////////////////////////////////////////////////////////////////////////////
// Pipelined multiplier returning the low word of the product
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module exec_mul
  import riscv_isa_pkg::*;
  import core_uarch_pkg::*;
#(
  parameter int MUL_STAGES = 3
) (
  input  logic         clock,
  input  logic         reset,
  input  exec_req_t    req,
  output exec_result_t result
);

  exec_result_t stage [MUL_STAGES];
  xlen_t        product;

  // Low 32 bits are the same for signed and unsigned operands
  assign product = req.operand_a * req.operand_b;

  // Product is formed into the first stage, later stages only delay it
  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < MUL_STAGES; i++) begin
        stage[i].valid <= 1'b0;
      end
    end else begin
      stage[0].valid     <= req.valid;
      stage[0].tag       <= req.tag;
      stage[0].rd        <= req.rd;
      stage[0].writes_rd <= req.writes_rd;
      stage[0].data      <= product;
      for (int i = 1; i < MUL_STAGES; i++) begin
        stage[i] <= stage[i-1];
      end
    end
  end

  assign result = stage[MUL_STAGES-1];

endmodule

//--- inst_buffer.sv
////////////////////////////////////////////////////////////////////////////
// Credit-fed circular FIFO of raw instruction words
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module inst_buffer
  import riscv_isa_pkg::*;
#(
  parameter int BUFFER_DEPTH = 4
) (
  input  logic  clock,
  input  logic  reset,
  input  logic  inst_valid,
  input  xlen_t inst_word,
  input  logic  pop,
  output logic  head_valid,
  output xlen_t head_word,
  output logic  credit_return
);

  localparam int PTR_W = (BUFFER_DEPTH > 1) ? $clog2(BUFFER_DEPTH) : 1;
  localparam int CNT_W = $clog2(BUFFER_DEPTH + 1);

  xlen_t            mem [BUFFER_DEPTH];
  logic [PTR_W-1:0] rd_ptr;
  logic [PTR_W-1:0] wr_ptr;
  logic [CNT_W-1:0] count;
  logic             take;
  logic             full;

  assign head_valid    = (count != '0);
  assign head_word     = mem[rd_ptr];
  assign take          = pop && head_valid;
  assign full          = (count == CNT_W'(BUFFER_DEPTH));
  // Every word that leaves hands one credit back
  assign credit_return = take;

  always_ff @(posedge clock) begin
    if (reset) begin
      rd_ptr <= '0;
      wr_ptr <= '0;
      count  <= '0;
    end else begin
      if (inst_valid) begin
        wr_ptr <= (wr_ptr == PTR_W'(BUFFER_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (take) begin
        rd_ptr <= (rd_ptr == PTR_W'(BUFFER_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      case ({inst_valid, take})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (inst_valid) begin
      mem[wr_ptr] <= inst_word;
    end
  end

  // Producer must hold a credit, so no word arrives into a full FIFO
  a_no_credit_overrun : assert property (
    @(posedge clock) disable iff (reset) inst_valid |-> !full
  );

endmodule

//--- inst_decode.sv
////////////////////////////////////////////////////////////////////////////
// Decode of the buffer head into a registered micro-op
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module inst_decode
  import riscv_isa_pkg::*;
  import core_uarch_pkg::*;
(
  input  logic      clock,
  input  logic      reset,
  input  logic      head_valid,
  input  xlen_t     head_word,
  input  logic      uop_ready,
  output logic      pop,
  output micro_op_t uop
);

  inst_word_u word;
  micro_op_t  dec;
  alu_op_t    f3_op;
  logic       f3_legal;
  logic       legal;
  logic       load;

  assign word = head_word;

  // Register is free when empty or when its micro-op issues this cycle
  assign load = !uop.valid || uop_ready;
  assign pop  = head_valid && load;

  // ALU operation shared by the R and I forms
  always_comb begin
    f3_legal = 1'b1;
    case (word.r.funct3)
      FUNCT3_ADD_SUB: f3_op = OP_ADD;
      FUNCT3_SLT:     f3_op = OP_SLT;
      FUNCT3_XOR:     f3_op = OP_XOR;
      FUNCT3_OR:      f3_op = OP_OR;
      FUNCT3_AND:     f3_op = OP_AND;
      default: begin
        f3_op    = OP_ADD;
        f3_legal = 1'b0;
      end
    endcase
  end

  always_comb begin
    dec       = '0;
    dec.valid = head_valid;
    dec.op    = f3_op;
    dec.rd    = word.r.rd;
    dec.rs1   = word.r.rs1;
    dec.rs2   = word.r.rs2;
    dec.imm   = {{20{word.i.imm[11]}}, word.i.imm};
    legal     = 1'b0;
    case (word.r.opcode)
      OPCODE_OP: begin
        dec.uses_rs2 = 1'b1;
        if (word.r.funct7 == FUNCT7_MULDIV) begin
          dec.op     = OP_MUL;
          dec.is_mul = 1'b1;
          legal      = (word.r.funct3 == FUNCT3_MUL);
        end else if (word.r.funct7 == FUNCT7_SUB) begin
          dec.op = OP_SUB;
          legal  = (word.r.funct3 == FUNCT3_ADD_SUB);
        end else if (word.r.funct7 == FUNCT7_ZERO) begin
          legal = f3_legal;
        end
      end
      OPCODE_OP_IMM: legal = f3_legal;
      default:       legal = 1'b0;
    endcase

    // Illegal words carry no register effects into issue
    dec.illegal = !legal;
    if (!legal) begin
      dec.uses_rs2 = 1'b0;
      dec.is_mul   = 1'b0;
    end
    dec.writes_rd = legal && (word.r.rd != '0);
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      uop.valid <= 1'b0;
    end else if (load) begin
      uop <= dec;
    end
  end

endmodule

//--- issue_stage.sv
////////////////////////////////////////////////////////////////////////////
// In-order issue with a busy-bit scoreboard, ROB tag allocation,
// register read and dispatch to the ALU or MUL pipe
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module issue_stage
  import riscv_isa_pkg::*;
  import core_uarch_pkg::*;
(
  input  logic         clock,
  input  logic         reset,
  input  micro_op_t    uop,
  input  logic         rob_full,
  input  rob_tag_t     rob_free_tag,
  input  exec_result_t alu_result,
  input  exec_result_t mul_result,
  input  xlen_t        rs1_data,
  input  xlen_t        rs2_data,
  output logic         uop_ready,
  output logic         alloc,
  output commit_t      alloc_entry,
  output reg_idx_t     rs1_addr,
  output reg_idx_t     rs2_addr,
  output exec_req_t    alu_req,
  output exec_req_t    mul_req
);

  logic [31:0] busy;
  logic        rs1_busy;
  logic        rs2_busy;
  logic        rd_busy;
  logic        rs1_pending;
  logic        rs2_pending;
  logic        fire;
  exec_req_t   req;

  assign rs1_addr = uop.rs1;
  assign rs2_addr = uop.rs2;

  // RAW on either source, WAW on the destination
  assign rs1_busy = !uop.illegal && busy[uop.rs1];
  assign rs2_busy = uop.uses_rs2 && busy[uop.rs2];
  assign rd_busy  = uop.writes_rd && busy[uop.rd];

  assign fire      = uop.valid && !rob_full && !rs1_busy && !rs2_busy && !rd_busy;
  assign uop_ready = fire;
  assign alloc     = fire;

  // Illegal ops enter the ROB complete and skip both pipes
  assign alloc_entry.rd        = uop.rd;
  assign alloc_entry.writes_rd = uop.writes_rd;
  assign alloc_entry.illegal   = uop.illegal;
  assign alloc_entry.data      = '0;

  assign req.valid     = fire && !uop.illegal;
  assign req.op        = uop.op;
  assign req.tag       = rob_free_tag;
  assign req.rd        = uop.rd;
  assign req.writes_rd = uop.writes_rd;
  assign req.operand_a = rs1_data;
  assign req.operand_b = uop.uses_rs2 ? rs2_data : uop.imm;

  always_comb begin
    alu_req       = req;
    mul_req       = req;
    alu_req.valid = req.valid && !uop.is_mul;
    mul_req.valid = req.valid && uop.is_mul;
  end

  // A newly issued writer claims its register after any writeback clears
  always_ff @(posedge clock) begin
    if (reset) begin
      busy <= '0;
    end else begin
      if (alu_result.valid && alu_result.writes_rd) begin
        busy[alu_result.rd] <= 1'b0;
      end
      if (mul_result.valid && mul_result.writes_rd) begin
        busy[mul_result.rd] <= 1'b0;
      end
      if (fire && uop.writes_rd) begin
        busy[uop.rd] <= 1'b1;
      end
    end
  end

  // A writeback landing on a source this cycle means its read is stale
  assign rs1_pending =
    (alu_result.valid && alu_result.writes_rd && alu_result.rd == rs1_addr) ||
    (mul_result.valid && mul_result.writes_rd && mul_result.rd == rs1_addr);
  assign rs2_pending = uop.uses_rs2 && (
    (alu_result.valid && alu_result.writes_rd && alu_result.rd == rs2_addr) ||
    (mul_result.valid && mul_result.writes_rd && mul_result.rd == rs2_addr));

  // Register file values are final by the time any request reads them
  a_no_busy_source : assert property (
    @(posedge clock) disable iff (reset)
      (alu_req.valid || mul_req.valid) |-> !rs1_pending && !rs2_pending
  );

endmodule

//--- ooo_core.f
+incdir+.
riscv_isa_pkg.sv
core_uarch_pkg.sv
inst_buffer.sv
inst_decode.sv
issue_stage.sv
reg_file.sv
exec_alu.sv
exec_mul.sv
reorder_buffer.sv
ooo_core.sv
tb_ooo_core.sv

//--- ooo_core.sv
////////////////////////////////////////////////////////////////////////////
// Core top level with buffer, decode, issue, register file,
// ALU and MUL pipes, and reorder buffer
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module ooo_core
  import riscv_isa_pkg::*;
  import core_uarch_pkg::*;
#(
  parameter int BUFFER_DEPTH = 4,
  parameter int MUL_STAGES   = 3
) (
  input  logic    clock,
  input  logic    reset,
  input  logic    inst_valid,
  input  xlen_t   inst_word,
  output logic    credit_return,
  output logic    commit_valid,
  output commit_t commit
);

  logic         head_valid;
  xlen_t        head_word;
  logic         pop;
  micro_op_t    uop;
  logic         uop_ready;
  logic         rob_full;
  rob_tag_t     rob_free_tag;
  logic         alloc;
  commit_t      alloc_entry;
  reg_idx_t     rs1_addr;
  reg_idx_t     rs2_addr;
  xlen_t        rs1_data;
  xlen_t        rs2_data;
  exec_req_t    alu_req;
  exec_req_t    mul_req;
  exec_result_t alu_result;
  exec_result_t mul_result;

  inst_buffer #(
    .BUFFER_DEPTH (BUFFER_DEPTH)
  ) u_buffer (
    .clock         (clock),
    .reset         (reset),
    .inst_valid    (inst_valid),
    .inst_word     (inst_word),
    .pop           (pop),
    .head_valid    (head_valid),
    .head_word     (head_word),
    .credit_return (credit_return)
  );

  inst_decode u_decode (
    .clock      (clock),
    .reset      (reset),
    .head_valid (head_valid),
    .head_word  (head_word),
    .uop_ready  (uop_ready),
    .pop        (pop),
    .uop        (uop)
  );

  issue_stage u_issue (
    .clock        (clock),
    .reset        (reset),
    .uop          (uop),
    .rob_full     (rob_full),
    .rob_free_tag (rob_free_tag),
    .alu_result   (alu_result),
    .mul_result   (mul_result),
    .rs1_data     (rs1_data),
    .rs2_data     (rs2_data),
    .uop_ready    (uop_ready),
    .alloc        (alloc),
    .alloc_entry  (alloc_entry),
    .rs1_addr     (rs1_addr),
    .rs2_addr     (rs2_addr),
    .alu_req      (alu_req),
    .mul_req      (mul_req)
  );

  reg_file u_reg_file (
    .clock      (clock),
    .reset      (reset),
    .rs1_addr   (rs1_addr),
    .rs2_addr   (rs2_addr),
    .alu_result (alu_result),
    .mul_result (mul_result),
    .rs1_data   (rs1_data),
    .rs2_data   (rs2_data)
  );

  exec_alu u_alu (
    .clock  (clock),
    .reset  (reset),
    .req    (alu_req),
    .result (alu_result)
  );

  exec_mul #(
    .MUL_STAGES (MUL_STAGES)
  ) u_mul (
    .clock  (clock),
    .reset  (reset),
    .req    (mul_req),
    .result (mul_result)
  );

  reorder_buffer u_rob (
    .clock        (clock),
    .reset        (reset),
    .alloc        (alloc),
    .alloc_entry  (alloc_entry),
    .alu_result   (alu_result),
    .mul_result   (mul_result),
    .rob_full     (rob_full),
    .rob_free_tag (rob_free_tag),
    .commit_valid (commit_valid),
    .commit       (commit)
  );

endmodule

//--- reg_file.sv
////////////////////////////////////////////////////////////////////////////
// Architectural register file, two reads and one write port per pipe
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module reg_file
  import riscv_isa_pkg::*;
  import core_uarch_pkg::*;
(
  input  logic         clock,
  input  logic         reset,
  input  reg_idx_t     rs1_addr,
  input  reg_idx_t     rs2_addr,
  input  exec_result_t alu_result,
  input  exec_result_t mul_result,
  output xlen_t        rs1_data,
  output xlen_t        rs2_data
);

  xlen_t regs [32];

  assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
  assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

  // Architectural state starts at zero
  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else begin
      if (alu_result.valid && alu_result.writes_rd) begin
        regs[alu_result.rd] <= alu_result.data;
      end
      if (mul_result.valid && mul_result.writes_rd) begin
        regs[mul_result.rd] <= mul_result.data;
      end
    end
  end

  // The scoreboard keeps two in-flight writers off one register
  a_no_dual_write : assert property (
    @(posedge clock) disable iff (reset)
      !(alu_result.valid && alu_result.writes_rd &&
        mul_result.valid && mul_result.writes_rd &&
        alu_result.rd == mul_result.rd)
  );

endmodule

//--- reorder_buffer.sv
////////////////////////////////////////////////////////////////////////////
// Reorder buffer that completes out of order and retires in order
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module reorder_buffer
  import core_uarch_pkg::*;
(
  input  logic         clock,
  input  logic         reset,
  input  logic         alloc,
  input  commit_t      alloc_entry,
  input  exec_result_t alu_result,
  input  exec_result_t mul_result,
  output logic         rob_full,
  output rob_tag_t     rob_free_tag,
  output logic         commit_valid,
  output commit_t      commit
);

  commit_t              entry [ROB_DEPTH];
  logic [ROB_DEPTH-1:0] slot_valid;
  logic [ROB_DEPTH-1:0] complete;
  rob_tag_t             head;
  rob_tag_t             tail;

  // Slots from head to tail are always occupied, so tail holds one only when full
  assign rob_full     = slot_valid[tail];
  assign rob_free_tag = tail;

  assign commit_valid = slot_valid[head] && complete[head];
  assign commit       = entry[head];

  always_ff @(posedge clock) begin
    if (reset) begin
      head       <= '0;
      tail       <= '0;
      slot_valid <= '0;
      complete   <= '0;
    end else begin
      if (commit_valid) begin
        slot_valid[head] <= 1'b0;
        head             <= head + 1'b1;
      end
      if (alloc) begin
        slot_valid[tail] <= 1'b1;
        complete[tail]   <= alloc_entry.illegal;
        tail             <= tail + 1'b1;
      end
      if (alu_result.valid) begin
        complete[alu_result.tag] <= 1'b1;
      end
      if (mul_result.valid) begin
        complete[mul_result.tag] <= 1'b1;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (alloc) begin
      entry[tail] <= alloc_entry;
    end
    if (alu_result.valid) begin
      entry[alu_result.tag].data <= alu_result.data;
    end
    if (mul_result.valid) begin
      entry[mul_result.tag].data <= mul_result.data;
    end
  end

  // Each pipe result lands on a live slot that is still waiting for it
  a_alu_result_slot : assert property (
    @(posedge clock) disable iff (reset)
      alu_result.valid |-> slot_valid[alu_result.tag] && !complete[alu_result.tag]
  );

  a_mul_result_slot : assert property (
    @(posedge clock) disable iff (reset)
      mul_result.valid |-> slot_valid[mul_result.tag] && !complete[mul_result.tag]
  );

endmodule

//--- riscv_isa_pkg.sv
////////////////////////////////////////////////////////////////////////////
// RV32 instruction formats, opcode and function codes, and the union
// that reads one instruction word in both the R and the I format
////////////////////////////////////////////////////////////////////////////
package riscv_isa_pkg;

  typedef logic [4:0]  reg_idx_t;
  typedef logic [31:0] xlen_t;

  // R format used by register ops and MUL
  typedef struct packed {
    logic [6:0] funct7;
    reg_idx_t   rs2;
    reg_idx_t   rs1;
    logic [2:0] funct3;
    reg_idx_t   rd;
    logic [6:0] opcode;
  } r_type_t;

  // I format used by the immediate ALU ops
  typedef struct packed {
    logic [11:0] imm;
    reg_idx_t    rs1;
    logic [2:0]  funct3;
    reg_idx_t    rd;
    logic [6:0]  opcode;
  } i_type_t;

  // Opcode, rd and rs1 sit at the same bits in both readings
  typedef union packed {
    r_type_t r;
    i_type_t i;
  } inst_word_u;

  localparam logic [6:0] OPCODE_OP     = 7'b0110011;
  localparam logic [6:0] OPCODE_OP_IMM = 7'b0010011;

  localparam logic [6:0] FUNCT7_ZERO   = 7'b0000000;
  localparam logic [6:0] FUNCT7_SUB    = 7'b0100000;
  localparam logic [6:0] FUNCT7_MULDIV = 7'b0000001;

  localparam logic [2:0] FUNCT3_ADD_SUB = 3'b000;
  localparam logic [2:0] FUNCT3_SLT     = 3'b010;
  localparam logic [2:0] FUNCT3_XOR     = 3'b100;
  localparam logic [2:0] FUNCT3_OR      = 3'b110;
  localparam logic [2:0] FUNCT3_AND     = 3'b111;
  localparam logic [2:0] FUNCT3_MUL     = 3'b000;

endpackage

//--- tb_ooo_vectors.svh
////////////////////////////////////////////////////////////////////////////
// Stimulus table for the core testbench: test names, gap control per
// test, and the instruction words in program order
////////////////////////////////////////////////////////////////////////////

// Each table entry is {test index, 32-bit instruction word}
localparam int NUM_TESTS = 6;
localparam int NUM_WORDS = 50;

string test_names [NUM_TESTS] = '{
  "alu_independent",
  "raw_chain",
  "mul_overlap",
  "x0_write",
  "illegal_encoding",
  "full_rate"
};

// Random idle gaps between words, off for the full-rate test
bit use_gaps [NUM_TESTS] = '{1'b1, 1'b1, 1'b1, 1'b1, 1'b1, 1'b0};

logic [39:0] vectors [NUM_WORDS] = '{
  // addi x1,x0,100  addi x2,x0,-7  xori x3,x0,0x5a5  ori x4,x0,0xf0
  {8'd0, 32'h06400093}, {8'd0, 32'hff900113}, {8'd0, 32'h5a504193}, {8'd0, 32'h0f006213},
  // andi x5,x1,0x7c  slti x6,x2,-1  add x7,x1,x2  sub x8,x1,x2
  {8'd0, 32'h07c0f293}, {8'd0, 32'hfff12313}, {8'd0, 32'h002083b3}, {8'd0, 32'h40208433},
  // and x9,x3,x4  or x10,x3,x4  xor x11,x1,x3  slt x12,x2,x1
  {8'd0, 32'h0041f4b3}, {8'd0, 32'h0041e533}, {8'd0, 32'h0030c5b3}, {8'd0, 32'h00112633},
  // addi x13,x0,3  add x14,x13,x13  sub x15,x14,x13  xor x16,x13,x15
  {8'd1, 32'h00300693}, {8'd1, 32'h00d68733}, {8'd1, 32'h40d707b3}, {8'd1, 32'h00f6c833},
  // addi x16,x16,-1 is RAW and WAW on x16
  {8'd1, 32'hfff80813}, {8'd1, 32'h00e828b3}, {8'd1, 32'h00f8e933}, {8'd1, 32'h010979b3},
  // mul x20,x1,x2  addi x21,x0,9  xor x22,x3,x4  mul x23,x21,x13
  {8'd2, 32'h02208a33}, {8'd2, 32'h00900a93}, {8'd2, 32'h0041cb33}, {8'd2, 32'h02da8bb3},
  // mul x24,x3,x4  mul x25,x2,x2  add x26,x20,x23  ori x27,x0,1
  {8'd2, 32'h02418c33}, {8'd2, 32'h02210cb3}, {8'd2, 32'h017a0d33}, {8'd2, 32'h00106d93},
  // addi x0,x1,5  add x0,x1,x2  mul x0,x2,x3  add x28,x0,x0  or x29,x0,x1
  {8'd3, 32'h00508013}, {8'd3, 32'h00208033}, {8'd3, 32'h02310033}, {8'd3, 32'h00000e33},
  {8'd3, 32'h00106eb3},
  // Zero word, all ones, bad funct7, slli, sll, mulh
  {8'd4, 32'h00000000}, {8'd4, 32'hffffffff}, {8'd4, 32'h20208f33}, {8'd4, 32'h00109f13},
  {8'd4, 32'h00209f33}, {8'd4, 32'h02209f33},
  // add x30,x1,x30 reads x30, which the illegal words left at zero
  {8'd4, 32'h01e08f33},
  // Back-to-back immediates into x1..x8
  {8'd5, 32'h00b00093}, {8'd5, 32'hed400113}, {8'd5, 32'h33304193}, {8'd5, 32'h44406213},
  {8'd5, 32'h7ff07293}, {8'd5, 32'h00102313}, {8'd5, 32'h7ff00393}, {8'd5, 32'h80000413},
  // mul x9,x1,x2  add x10,x7,x8
  {8'd5, 32'h022084b3}, {8'd5, 32'h00838533}
};

//--- tb_ooo_core.sv
////////////////////////////////////////////////////////////////////////////
// Testbench for the core: clock and reset, credit-respecting driver,
// architectural reference model, commit checks and watchdog
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module tb_ooo_core
  import riscv_isa_pkg::*;
  import core_uarch_pkg::*;
();

  localparam int BUFFER_DEPTH    = 4;
  localparam int MUL_STAGES      = 3;
  localparam int RESET_CYCLES    = 16;
  localparam int CYCLES_PER_WORD = 40;

  `include "tb_ooo_vectors.svh"

  logic    clock;
  logic    reset;
  logic    inst_valid;
  xlen_t   inst_word;
  logic    credit_return;
  logic    commit_valid;
  commit_t commit;

  // Architectural state of the reference model
  xlen_t       model_regs [32];
  commit_t     expected_q [$];
  int          expected_test_q [$];
  logic [31:0] lfsr_state       = 32'hb2aa_d417;
  int          words_sent       = 0;
  int          words_seen       = 0;
  int          credits_returned = 0;
  int          commits_seen     = 0;

  ooo_core #(
    .BUFFER_DEPTH (BUFFER_DEPTH),
    .MUL_STAGES   (MUL_STAGES)
  ) dut0 (
    .clock         (clock),
    .reset         (reset),
    .inst_valid    (inst_valid),
    .inst_word     (inst_word),
    .credit_return (credit_return),
    .commit_valid  (commit_valid),
    .commit        (commit)
  );

  initial begin
    clock = 1'b0;
    forever #2 clock = ~clock;
  end

  task automatic stop_with_error(input string msg);
    $display("%s", msg);
    $display("Result: FAILED");
    $fatal(1);
  endtask

  task automatic compare_values(input string name, input logic [63:0] expected,
                                input logic [63:0] actual);
    if (actual !== expected) begin
      stop_with_error($sformatf("Fail %s: expected %h, actual %h", name, expected, actual));
    end
  endtask

  // Fibonacci LFSR, taps 32 22 2 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic draw_bits(input int n, output int value);
    value = 0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_step(lfsr_state);
      value      = (value << 1) | int'(lfsr_state[0]);
    end
  endtask

  // ALU result for the funct3 codes shared by register and immediate forms
  task automatic ref_funct3(input logic [2:0] funct3, input xlen_t a, input xlen_t b,
                            output xlen_t y, output logic ok);
    ok = 1'b1;
    y  = '0;
    case (funct3)
      3'b000:  y = a + b;
      3'b010:  y = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      3'b100:  y = a ^ b;
      3'b110:  y = a | b;
      3'b111:  y = a & b;
      default: ok = 1'b0;
    endcase
  endtask

  // Executes one word in program order and queues its commit record
  task automatic run_model(input int test, input xlen_t word);
    xlen_t   a;
    xlen_t   b;
    xlen_t   imm;
    xlen_t   y;
    logic    ok;
    commit_t exp;
    a   = model_regs[word[19:15]];
    b   = model_regs[word[24:20]];
    imm = {{20{word[31]}}, word[31:20]};
    y   = '0;
    ok  = 1'b0;
    case (word[6:0])
      7'b0110011: begin
        if (word[31:25] == 7'b0000001) begin
          ok = (word[14:12] == 3'b000);
          y  = a * b;
        end else if (word[31:25] == 7'b0100000) begin
          ok = (word[14:12] == 3'b000);
          y  = a - b;
        end else if (word[31:25] == 7'b0000000) begin
          ref_funct3(word[14:12], a, b, y, ok);
        end
      end
      7'b0010011: ref_funct3(word[14:12], a, imm, y, ok);
      default:    ok = 1'b0;
    endcase
    exp.rd        = word[11:7];
    exp.writes_rd = ok && (word[11:7] != 5'd0);
    exp.illegal   = !ok;
    exp.data      = ok ? y : '0;
    if (exp.writes_rd) begin
      model_regs[word[11:7]] = y;
    end
    expected_q.push_back(exp);
    expected_test_q.push_back(test);
  endtask

  // Driver and end of run
  initial begin
    int gap_left;
    int w;
    reset      = 1'b1;
    inst_valid = 1'b0;
    inst_word  = '0;
    gap_left   = 0;
    w          = 0;
    for (int r = 0; r < 32; r++) begin
      model_regs[r] = '0;
    end
    repeat (RESET_CYCLES) @(posedge clock);
    reset <= 1'b0;

    while (w < NUM_WORDS) begin
      @(posedge clock);
      if (gap_left == 0 && BUFFER_DEPTH - words_sent + credits_returned > 0) begin
        inst_valid <= 1'b1;
        inst_word  <= vectors[w][31:0];
        run_model(vectors[w][39:32], vectors[w][31:0]);
        words_sent++;
        w++;
        if (w < NUM_WORDS && use_gaps[vectors[w][39:32]]) begin
          draw_bits(2, gap_left);
        end
      end else begin
        inst_valid <= 1'b0;
        if (gap_left > 0) begin
          gap_left--;
        end
      end
    end
    @(posedge clock);
    inst_valid <= 1'b0;

    wait (commits_seen == NUM_WORDS);
    // Quiet period so a stray extra commit or credit is still caught
    repeat (8) @(negedge clock);
    compare_values("credit_balance", words_sent, credits_returned);
    $display("Result: PASSED");
    $finish;
  end

  // Monitor samples mid-cycle, away from the driving edge
  always @(negedge clock) begin
    if (!reset) begin
      if (words_seen == 0 && (credit_return || commit_valid)) begin
        stop_with_error("Core returned a credit or committed before any word was sent");
      end
      if (inst_valid) begin
        words_seen++;
        // A credit returned in this same cycle is not yet usable
        if (words_seen - credits_returned > BUFFER_DEPTH) begin
          stop_with_error("Producer sent a word without holding a credit");
        end
      end
      if (credit_return) begin
        credits_returned++;
      end
      if (commit_valid) begin
        if (expected_q.size() == 0) begin
          stop_with_error("Commit arrived with no instruction outstanding");
        end else begin
          compare_values(test_names[expected_test_q[0]], expected_q[0], commit);
          expected_q.pop_front();
          expected_test_q.pop_front();
          commits_seen++;
        end
      end
    end
  end

  initial begin
    repeat (RESET_CYCLES + CYCLES_PER_WORD * NUM_WORDS) @(posedge clock);
    stop_with_error("Timeout: commits stopped before every table instruction retired");
  end

endmodule
